// ==== source/float_pkg.sv ====
package float_pkg;

  // IEEE 754 single-precision fields
  typedef logic [31:0] float_t;
  typedef logic [7:0]  exp_t;
  typedef logic [22:0] mant_t;
  typedef logic [23:0] sig_t;                   // Fraction with hidden bit

  localparam exp_t EXP_BIAS = 8'd127;
  localparam exp_t EXP_MAX  = 8'd255;           // Inf and NaN exponent

  localparam float_t QNAN    = 32'h7FC0_0000;   // Canonical quiet NaN
  localparam float_t POS_INF = 32'h7F80_0000;

  localparam int FP_LATENCY = 2;                // Pipeline depth of every unit

  // Counts leading zeros of a 32-bit word and gives 32 for zero
  function automatic logic [5:0] lead_zeros(input float_t v);
    logic [5:0] n;
    n = 6'd32;
    for (int i = 0; i < 32; i++) begin
      if (v[i]) begin
        n = 6'(31 - i);                         // Highest set bit wins
      end
    end
    return n;
  endfunction

endpackage

// ==== source/fpu_pkg.sv ====
package fpu_pkg;

  // Function codes as seen on func_i
  typedef logic [2:0] func_t;

  localparam func_t FPU_CVTIS = 3'd0;  // Int to float
  localparam func_t FPU_CVTSI = 3'd1;  // Float to int
  localparam func_t FPU_SQRT  = 3'd2;  // Not implemented
  localparam func_t FPU_NEG   = 3'd3;
  localparam func_t FPU_ADD   = 3'd4;
  localparam func_t FPU_SUB   = 3'd5;  // Bit 0 selects subtract in the adder
  localparam func_t FPU_MUL   = 3'd6;
  localparam func_t FPU_DIV   = 3'd7;  // Not implemented

endpackage

// ==== source/fp_addsub.sv ====
`timescale 1ns/100ps

module fp_addsub (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  float_pkg::float_t a_i,
  input  float_pkg::float_t b_i,
  input  logic              sub_i,
  output float_pkg::float_t result_o,
  output logic              overflow_o,
  output logic              underflow_o,
  output logic              nan_o
);

  float_pkg::exp_t  a_exp;
  float_pkg::exp_t  b_exp;
  float_pkg::mant_t a_man;
  float_pkg::mant_t b_man;
  logic             a_sign;
  logic             b_sign;
  logic             a_inf;
  logic             b_inf;
  logic             a_nan;
  logic             b_nan;
  float_pkg::sig_t  a_sig;
  float_pkg::sig_t  b_sig;
  logic [30:0]      a_mag;
  logic [30:0]      b_mag;

  logic             big_sign;
  float_pkg::exp_t  big_exp;
  float_pkg::sig_t  big_sig;
  float_pkg::sig_t  small_sig;
  float_pkg::exp_t  exp_diff;
  logic [26:0]      small_ext;
  logic [26:0]      small_shift;
  logic             sticky;

  logic             s1_sign;
  float_pkg::exp_t  s1_exp;
  logic [26:0]      s1_big;
  logic [26:0]      s1_small;
  logic             s1_sub;
  logic             s1_nan;
  logic             s1_inf;
  logic             s1_inf_sign;

  logic [27:0]        sum;
  logic [5:0]         lz;
  logic [27:0]        norm;
  logic signed [9:0]  exp_res;
  float_pkg::float_t  res_d;
  logic               ovf_d;
  logic               unf_d;
  logic               nan_d;

  assign a_sign = a_i[31];
  assign b_sign = b_i[31] ^ sub_i;               // Subtract adds the negated operand
  assign a_exp  = a_i[30:23];
  assign b_exp  = b_i[30:23];
  assign a_man  = a_i[22:0];
  assign b_man  = b_i[22:0];
  assign a_inf  = (a_exp == float_pkg::EXP_MAX) && (a_man == '0);
  assign b_inf  = (b_exp == float_pkg::EXP_MAX) && (b_man == '0);
  assign a_nan  = (a_exp == float_pkg::EXP_MAX) && (a_man != '0);
  assign b_nan  = (b_exp == float_pkg::EXP_MAX) && (b_man != '0);
  assign a_sig  = (a_exp == '0) ? '0 : {1'b1, a_man};  // Denormals read as zero
  assign b_sig  = (b_exp == '0) ? '0 : {1'b1, b_man};
  assign a_mag  = (a_exp == '0) ? '0 : a_i[30:0];
  assign b_mag  = (b_exp == '0) ? '0 : b_i[30:0];

  // Order by magnitude, then align the smaller significand
  always_comb begin
    if (b_mag > a_mag) begin
      big_sign  = b_sign;
      big_exp   = b_exp;
      big_sig   = b_sig;
      small_sig = a_sig;
      exp_diff  = b_exp - a_exp;
    end else begin
      big_sign  = a_sign;
      big_exp   = a_exp;
      big_sig   = a_sig;
      small_sig = b_sig;
      exp_diff  = a_exp - b_exp;
    end
    small_ext = {small_sig, 3'b000};
    if (exp_diff > 8'd26) begin
      small_shift = '0;
      sticky      = |small_sig;
    end else begin
      small_shift = small_ext >> exp_diff[4:0];
      sticky      = |(small_ext & ~({27{1'b1}} << exp_diff[4:0]));
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_sign     <= 1'b0;
      s1_exp      <= '0;
      s1_big      <= '0;
      s1_small    <= '0;
      s1_sub      <= 1'b0;
      s1_nan      <= 1'b0;
      s1_inf      <= 1'b0;
      s1_inf_sign <= 1'b0;
    end else begin
      s1_sign     <= big_sign;
      s1_exp      <= big_exp;
      s1_big      <= {big_sig, 3'b000};
      s1_small    <= {small_shift[26:1], small_shift[0] | sticky};
      s1_sub      <= a_sign ^ b_sign;
      s1_nan      <= a_nan | b_nan | (a_inf & b_inf & (a_sign ^ b_sign));
      s1_inf      <= a_inf | b_inf;
      s1_inf_sign <= a_inf ? a_sign : b_sign;
    end
  end

  // Stage two adds, normalizes and truncates
  always_comb begin
    if (s1_sub) begin
      sum = {1'b0, s1_big} - {1'b0, s1_small};   // Never negative since big is larger
    end else begin
      sum = {1'b0, s1_big} + {1'b0, s1_small};
    end
    lz      = float_pkg::lead_zeros({sum, 4'b0000});
    norm    = sum << lz[4:0];
    exp_res = {2'b00, s1_exp} + 10'd1 - {4'b0000, lz};
    res_d   = {s1_sign, exp_res[7:0], norm[26:4]};
    ovf_d   = 1'b0;
    unf_d   = 1'b0;
    nan_d   = 1'b0;
    if (s1_nan) begin
      res_d = float_pkg::QNAN;
      nan_d = 1'b1;
    end else if (s1_inf) begin
      res_d = {s1_inf_sign, float_pkg::POS_INF[30:0]};
    end else if (sum == '0) begin
      res_d = '0;                                // Exact cancellation gives +0
    end else if (exp_res >= $signed({2'b00, float_pkg::EXP_MAX})) begin
      res_d = {s1_sign, float_pkg::POS_INF[30:0]};
      ovf_d = 1'b1;
    end else if (exp_res <= 10'sd0) begin
      res_d = {s1_sign, 31'b0};
      unf_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      result_o    <= '0;
      overflow_o  <= 1'b0;
      underflow_o <= 1'b0;
      nan_o       <= 1'b0;
    end else begin
      result_o    <= res_d;
      overflow_o  <= ovf_d;
      underflow_o <= unf_d;
      nan_o       <= nan_d;
    end
  end

endmodule

// ==== source/fp_mult.sv ====
`timescale 1ns/100ps

module fp_mult (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  float_pkg::float_t a_i,
  input  float_pkg::float_t b_i,
  output float_pkg::float_t result_o,
  output logic              overflow_o,
  output logic              underflow_o,
  output logic              nan_o
);

  float_pkg::exp_t   a_exp;
  float_pkg::exp_t   b_exp;
  logic              a_zero;
  logic              b_zero;
  logic              a_inf;
  logic              b_inf;
  logic              a_nan;
  logic              b_nan;
  float_pkg::sig_t   a_sig;
  float_pkg::sig_t   b_sig;
  logic signed [9:0] exp_sum;

  logic              s1_sign;
  logic signed [9:0] s1_exp;
  logic [47:0]       s1_prod;
  logic              s1_nan;
  logic              s1_inf;
  logic              s1_zero;

  logic signed [9:0] norm_exp;
  float_pkg::mant_t  norm_mant;
  float_pkg::float_t res_d;
  logic              ovf_d;
  logic              unf_d;
  logic              nan_d;

  assign a_exp  = a_i[30:23];
  assign b_exp  = b_i[30:23];
  assign a_zero = (a_exp == '0);                 // Denormals count as zero
  assign b_zero = (b_exp == '0);
  assign a_inf  = (a_exp == float_pkg::EXP_MAX) && (a_i[22:0] == '0);
  assign b_inf  = (b_exp == float_pkg::EXP_MAX) && (b_i[22:0] == '0);
  assign a_nan  = (a_exp == float_pkg::EXP_MAX) && (a_i[22:0] != '0);
  assign b_nan  = (b_exp == float_pkg::EXP_MAX) && (b_i[22:0] != '0);
  assign a_sig  = a_zero ? '0 : {1'b1, a_i[22:0]};
  assign b_sig  = b_zero ? '0 : {1'b1, b_i[22:0]};
  assign exp_sum = {2'b00, a_exp} + {2'b00, b_exp} - {2'b00, float_pkg::EXP_BIAS};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_sign <= 1'b0;
      s1_exp  <= '0;
      s1_prod <= '0;
      s1_nan  <= 1'b0;
      s1_inf  <= 1'b0;
      s1_zero <= 1'b0;
    end else begin
      s1_sign <= a_i[31] ^ b_i[31];
      s1_exp  <= exp_sum;
      s1_prod <= a_sig * b_sig;
      s1_nan  <= a_nan | b_nan | (a_inf & b_zero) | (a_zero & b_inf);
      s1_inf  <= a_inf | b_inf;
      s1_zero <= a_zero | b_zero;
    end
  end

  // Product lies in [1,4), so at most one place of normalization
  always_comb begin
    if (s1_prod[47]) begin
      norm_exp  = s1_exp + 10'sd1;
      norm_mant = s1_prod[46:24];
    end else begin
      norm_exp  = s1_exp;
      norm_mant = s1_prod[45:23];
    end
    res_d = {s1_sign, norm_exp[7:0], norm_mant};
    ovf_d = 1'b0;
    unf_d = 1'b0;
    nan_d = 1'b0;
    if (s1_nan) begin
      res_d = float_pkg::QNAN;
      nan_d = 1'b1;
    end else if (s1_inf) begin
      res_d = {s1_sign, float_pkg::POS_INF[30:0]};
    end else if (s1_zero) begin
      res_d = {s1_sign, 31'b0};
    end else if (norm_exp >= $signed({2'b00, float_pkg::EXP_MAX})) begin
      res_d = {s1_sign, float_pkg::POS_INF[30:0]};
      ovf_d = 1'b1;
    end else if (norm_exp <= 10'sd0) begin
      res_d = {s1_sign, 31'b0};                  // Flush to zero
      unf_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      result_o    <= '0;
      overflow_o  <= 1'b0;
      underflow_o <= 1'b0;
      nan_o       <= 1'b0;
    end else begin
      result_o    <= res_d;
      overflow_o  <= ovf_d;
      underflow_o <= unf_d;
      nan_o       <= nan_d;
    end
  end

endmodule

// ==== source/fp_convert.sv ====
`timescale 1ns/100ps

module fp_convert (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  float_pkg::float_t a_i,
  input  fpu_pkg::func_t    func_i,
  output float_pkg::float_t result_o
);

  fpu_pkg::func_t    s1_func;
  float_pkg::float_t s1_a;
  float_pkg::float_t s1_abs;
  float_pkg::exp_t   s1_exp;
  float_pkg::sig_t   s1_sig;

  logic [5:0]        lz;
  float_pkg::float_t norm;
  float_pkg::exp_t   cvtis_exp;
  float_pkg::float_t cvtis_res;
  logic signed [9:0] unb_exp;
  float_pkg::float_t mag;
  float_pkg::float_t cvtsi_res;
  float_pkg::float_t res_d;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_func <= '0;
      s1_a    <= '0;
      s1_abs  <= '0;
      s1_exp  <= '0;
      s1_sig  <= '0;
    end else begin
      s1_func <= func_i;
      s1_a    <= a_i;
      s1_abs  <= a_i[31] ? -a_i : a_i;           // Magnitude of the signed integer
      s1_exp  <= a_i[30:23];
      s1_sig  <= (a_i[30:23] == '0) ? '0 : {1'b1, a_i[22:0]};
    end
  end

  // Integer to float with the low bits truncated
  always_comb begin
    lz        = float_pkg::lead_zeros(s1_abs);
    norm      = s1_abs << lz[4:0];
    cvtis_exp = float_pkg::EXP_BIAS + 8'd31 - {2'b00, lz};
    if (s1_abs == '0) begin
      cvtis_res = '0;
    end else begin
      cvtis_res = {s1_a[31], cvtis_exp, norm[30:8]};
    end
  end

  // Float to integer truncated toward zero
  always_comb begin
    unb_exp = {2'b00, s1_exp} - {2'b00, float_pkg::EXP_BIAS};
    if (unb_exp >= 10'sd23) begin
      mag = {8'b0, s1_sig} << (unb_exp[4:0] - 5'd23);
    end else begin
      mag = {8'b0, s1_sig} >> (5'd23 - unb_exp[4:0]);
    end
    if ((s1_exp == float_pkg::EXP_MAX) && (s1_sig[22:0] != '0)) begin
      cvtsi_res = '0;                            // NaN converts to zero
    end else if (unb_exp < 10'sd0) begin
      cvtsi_res = '0;
    end else if (unb_exp >= 10'sd31) begin
      cvtsi_res = s1_a[31] ? 32'h8000_0000 : 32'h7FFF_FFFF;
    end else begin
      cvtsi_res = s1_a[31] ? -mag : mag;
    end
  end

  always_comb begin
    case (s1_func)
      fpu_pkg::FPU_CVTIS: res_d = cvtis_res;
      fpu_pkg::FPU_CVTSI: res_d = cvtsi_res;
      fpu_pkg::FPU_NEG:   res_d = {~s1_a[31], s1_a[30:0]};
      default:            res_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      result_o <= '0;
    end else begin
      result_o <= res_d;
    end
  end

endmodule

// ==== source/fpu_control.sv ====
`timescale 1ns/100ps

module fpu_control (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  fpu_pkg::func_t    func_i,
  input  float_pkg::float_t addsub_result_i,
  input  logic              addsub_overflow_i,
  input  logic              addsub_underflow_i,
  input  logic              addsub_nan_i,
  input  float_pkg::float_t mult_result_i,
  input  logic              mult_overflow_i,
  input  logic              mult_underflow_i,
  input  logic              mult_nan_i,
  input  float_pkg::float_t convert_result_i,
  output float_pkg::float_t out_o,
  output logic              overflow_o,
  output logic              underflow_o,
  output logic              nan_o,
  output logic              divzero_o
);

  fpu_pkg::func_t func_q [float_pkg::FP_LATENCY];
  fpu_pkg::func_t func_sel;

  // Code follows its operands down the unit pipelines
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < float_pkg::FP_LATENCY; i++) begin
        func_q[i] <= '0;
      end
    end else begin
      func_q[0] <= func_i;
      for (int i = 1; i < float_pkg::FP_LATENCY; i++) begin
        func_q[i] <= func_q[i-1];
      end
    end
  end

  assign func_sel = func_q[float_pkg::FP_LATENCY-1];

  always_comb begin
    out_o       = '0;
    overflow_o  = 1'b0;
    underflow_o = 1'b0;
    nan_o       = 1'b0;
    case (func_sel)
      fpu_pkg::FPU_CVTIS,
      fpu_pkg::FPU_CVTSI,
      fpu_pkg::FPU_NEG: out_o = convert_result_i;  // Conversions raise no flags
      fpu_pkg::FPU_ADD,
      fpu_pkg::FPU_SUB: begin
        out_o       = addsub_result_i;
        overflow_o  = addsub_overflow_i;
        underflow_o = addsub_underflow_i;
        nan_o       = addsub_nan_i;
      end
      fpu_pkg::FPU_MUL: begin
        out_o       = mult_result_i;
        overflow_o  = mult_overflow_i;
        underflow_o = mult_underflow_i;
        nan_o       = mult_nan_i;
      end
      fpu_pkg::FPU_SQRT,
      fpu_pkg::FPU_DIV: out_o = '0;               // No sqrt or divide datapath
    endcase
  end

  assign divzero_o = 1'b0;

endmodule

// ==== source/fpu.sv ====
`timescale 1ns/100ps

module fpu (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  float_pkg::float_t in1_i,
  input  float_pkg::float_t in2_i,
  input  fpu_pkg::func_t    func_i,
  output float_pkg::float_t out_o,
  output logic              overflow_o,
  output logic              underflow_o,
  output logic              nan_o,
  output logic              divzero_o
);

  float_pkg::float_t addsub_result;
  logic              addsub_overflow;
  logic              addsub_underflow;
  logic              addsub_nan;
  float_pkg::float_t mult_result;
  logic              mult_overflow;
  logic              mult_underflow;
  logic              mult_nan;
  float_pkg::float_t convert_result;

  fp_addsub u_addsub (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .a_i         (in1_i),
    .b_i         (in2_i),
    .sub_i       (func_i[0]),                    // ADD and SUB differ in bit 0
    .result_o    (addsub_result),
    .overflow_o  (addsub_overflow),
    .underflow_o (addsub_underflow),
    .nan_o       (addsub_nan)
  );

  fp_mult u_mult (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .a_i         (in1_i),
    .b_i         (in2_i),
    .result_o    (mult_result),
    .overflow_o  (mult_overflow),
    .underflow_o (mult_underflow),
    .nan_o       (mult_nan)
  );

  fp_convert u_convert (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .a_i      (in2_i),                           // Unary ops take the second operand
    .func_i   (func_i),
    .result_o (convert_result)
  );

  fpu_control u_control (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .func_i             (func_i),
    .addsub_result_i    (addsub_result),
    .addsub_overflow_i  (addsub_overflow),
    .addsub_underflow_i (addsub_underflow),
    .addsub_nan_i       (addsub_nan),
    .mult_result_i      (mult_result),
    .mult_overflow_i    (mult_overflow),
    .mult_underflow_i   (mult_underflow),
    .mult_nan_i         (mult_nan),
    .convert_result_i   (convert_result),
    .out_o              (out_o),
    .overflow_o         (overflow_o),
    .underflow_o        (underflow_o),
    .nan_o              (nan_o),
    .divzero_o          (divzero_o)
  );

endmodule

// ==== tb/fpu_checker.sv ====
`timescale 1ns/100ps

module fpu_checker (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  float_pkg::float_t out_i,
  input  logic              overflow_i,
  input  logic              underflow_i,
  input  logic              nan_i,
  input  logic              divzero_i,
  input  logic              exp_valid_i,
  input  logic              exp_last_i,
  input  logic [127:0]      exp_name_i,
  input  float_pkg::float_t exp_result_i,
  input  logic              exp_overflow_i,
  input  logic              exp_underflow_i,
  input  logic              exp_nan_i,
  output int                fail_count_o,
  output logic              done_o
);

  int                pass_count = 0;
  int                fail_count = 0;
  logic              started = 1'b0;
  logic              summary_done = 1'b0;
  logic              idle_bad = 1'b0;
  float_pkg::float_t idle_out = '0;
  logic [3:0]        idle_flags = 4'b0000;

  assign fail_count_o = fail_count;
  assign done_o       = summary_done;

  // Name travels as left-justified bytes with zero padding dropped
  function automatic string name_text(input logic [127:0] v);
    string s;
    s = "";
    for (int i = 15; i >= 0; i--) begin
      if (v[i*8 +: 8] != 8'h00) begin
        s = $sformatf("%s%c", s, v[i*8 +: 8]);
      end
    end
    return s;
  endfunction

  // Flags print as overflow, underflow, nan, divzero
  task automatic log_result(input string name, input float_pkg::float_t exp_res,
                            input logic [3:0] exp_flags, input float_pkg::float_t act_res,
                            input logic [3:0] act_flags);
    if ((act_res === exp_res) && (act_flags === exp_flags)) begin
      pass_count++;
      $display("Pass  %s result %h flags %b", name, act_res, act_flags);
    end else begin
      fail_count++;
      $display("Error %s expected %h flags %b actual %h flags %b",
               name, exp_res, exp_flags, act_res, act_flags);
    end
  endtask

  // Outputs settle after the rising edge, so sample on the falling one
  always @(negedge clk_i) begin
    if (rst_n_i && !exp_valid_i && !started) begin
      if (!idle_bad && ({out_i, overflow_i, underflow_i, nan_i, divzero_i} !== '0)) begin
        idle_bad   = 1'b1;
        idle_out   = out_i;
        idle_flags = {overflow_i, underflow_i, nan_i, divzero_i};
      end
    end else if (exp_valid_i) begin
      if (!started) begin
        started = 1'b1;
        log_result("after_reset", '0, 4'b0000, idle_out, idle_flags);
      end
      log_result(name_text(exp_name_i), exp_result_i,
                 {exp_overflow_i, exp_underflow_i, exp_nan_i, 1'b0},
                 out_i, {overflow_i, underflow_i, nan_i, divzero_i});
      if (exp_last_i) begin
        $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
        summary_done = 1'b1;
      end
    end
  end

endmodule

// ==== tb/fpu_tb.sv ====
`timescale 1ns/100ps

module fpu_tb;

  localparam int CLK_PERIOD   = 20;
  localparam int DRIVE_SKEW   = 2;   // Inputs change this long after the rising edge
  localparam int RESET_CYCLES = 4;

  typedef struct packed {
    logic [127:0]      name;
    fpu_pkg::func_t    func;
    float_pkg::float_t in1;
    float_pkg::float_t in2;
    float_pkg::float_t result;
    logic              ovf;
    logic              unf;
    logic              nan;
  } vector_t;

  logic              clk;
  logic              rst_n;
  float_pkg::float_t in1;
  float_pkg::float_t in2;
  fpu_pkg::func_t    func;
  float_pkg::float_t result;
  logic              overflow;
  logic              underflow;
  logic              nan;
  logic              divzero;

  vector_t           table_q[$];
  logic              table_ready = 1'b0;
  vector_t           cur;
  logic              cur_valid;
  logic              cur_last;
  vector_t           d1;
  logic              d1_valid;
  logic              d1_last;
  vector_t           d2;
  logic              d2_valid;
  logic              d2_last;
  int                fail_count;
  logic              check_done;
  int                timeout_ns;

  function automatic logic [127:0] pack_name(input string s);
    logic [127:0] v;
    v = '0;
    for (int i = 0; (i < s.len()) && (i < 16); i++) begin
      v[(15 - i) * 8 +: 8] = s[i];
    end
    return v;
  endfunction

  task automatic add_vector(input string name, input fpu_pkg::func_t f,
                            input float_pkg::float_t a, input float_pkg::float_t b,
                            input float_pkg::float_t r, input logic o, input logic u,
                            input logic n);
    vector_t v;
    v.name   = pack_name(name);
    v.func   = f;
    v.in1    = a;
    v.in2    = b;
    v.result = r;
    v.ovf    = o;
    v.unf    = u;
    v.nan    = n;
    table_q.push_back(v);
  endtask

  // Expected values are IEEE single results truncated toward zero
  task automatic fill_table();
    add_vector("add_exact",     fpu_pkg::FPU_ADD,   32'h3FC00000, 32'h40100000, 32'h40700000, 0, 0, 0);
    add_vector("sub_cancel",    fpu_pkg::FPU_SUB,   32'h3F800000, 32'h3F800000, 32'h00000000, 0, 0, 0);
    add_vector("add_int",       fpu_pkg::FPU_ADD,   32'h40000000, 32'h40400000, 32'h40A00000, 0, 0, 0);
    add_vector("sub_negative",  fpu_pkg::FPU_SUB,   32'h40A00000, 32'h40F00000, 32'hC0200000, 0, 0, 0);
    add_vector("add_overflow",  fpu_pkg::FPU_ADD,   32'h7F7FFFFF, 32'h7F7FFFFF, 32'h7F800000, 1, 0, 0);
    add_vector("add_nan",       fpu_pkg::FPU_ADD,   32'h7F800001, 32'h3F800000, 32'h7FC00000, 0, 0, 1);
    add_vector("sub_inf_inf",   fpu_pkg::FPU_SUB,   32'h7F800000, 32'h7F800000, 32'h7FC00000, 0, 0, 1);
    add_vector("mul_exact",     fpu_pkg::FPU_MUL,   32'h40000000, 32'hC0800000, 32'hC1000000, 0, 0, 0);
    add_vector("mul_square",    fpu_pkg::FPU_MUL,   32'h3FC00000, 32'h3FC00000, 32'h40100000, 0, 0, 0);
    add_vector("mul_truncate",  fpu_pkg::FPU_MUL,   32'h40400000, 32'h3DCCCCCD, 32'h3E999999, 0, 0, 0);
    add_vector("mul_nan",       fpu_pkg::FPU_MUL,   32'hFFC00000, 32'h40000000, 32'h7FC00000, 0, 0, 1);
    add_vector("mul_zero_inf",  fpu_pkg::FPU_MUL,   32'h00000000, 32'h7F800000, 32'h7FC00000, 0, 0, 1);
    add_vector("mul_overflow",  fpu_pkg::FPU_MUL,   32'h7F000000, 32'hFF000000, 32'hFF800000, 1, 0, 0);
    add_vector("mul_underflow", fpu_pkg::FPU_MUL,   32'h00800000, 32'h00800000, 32'h00000000, 0, 1, 0);
    add_vector("cvtis_zero",    fpu_pkg::FPU_CVTIS, 32'h00000000, 32'h00000000, 32'h00000000, 0, 0, 0);
    add_vector("cvtis_minus7",  fpu_pkg::FPU_CVTIS, 32'h00000000, 32'hFFFFFFF9, 32'hC0E00000, 0, 0, 0);
    add_vector("cvtis_max",     fpu_pkg::FPU_CVTIS, 32'h00000000, 32'h7FFFFFFF, 32'h4EFFFFFF, 0, 0, 0);
    add_vector("cvtsi_3p9",     fpu_pkg::FPU_CVTSI, 32'h00000000, 32'h4079999A, 32'h00000003, 0, 0, 0);
    add_vector("cvtsi_m2p5",    fpu_pkg::FPU_CVTSI, 32'h00000000, 32'hC0200000, 32'hFFFFFFFE, 0, 0, 0);
    add_vector("cvtsi_big",     fpu_pkg::FPU_CVTSI, 32'h00000000, 32'h60AD78EC, 32'h7FFFFFFF, 0, 0, 0);
    add_vector("cvtsi_nan",     fpu_pkg::FPU_CVTSI, 32'h00000000, 32'h7FC00000, 32'h00000000, 0, 0, 0);
    add_vector("neg_pos",       fpu_pkg::FPU_NEG,   32'h00000000, 32'h3F800000, 32'hBF800000, 0, 0, 0);
    add_vector("neg_neg",       fpu_pkg::FPU_NEG,   32'h00000000, 32'hC0200000, 32'h40200000, 0, 0, 0);
    add_vector("sqrt_unsup",    fpu_pkg::FPU_SQRT,  32'h40800000, 32'h40800000, 32'h00000000, 0, 0, 0);
    add_vector("div_unsup",     fpu_pkg::FPU_DIV,   32'h3F800000, 32'h00000000, 32'h00000000, 0, 0, 0);
  endtask

  task automatic apply_vector(input vector_t v, input logic last);
    in1       = v.in1;
    in2       = v.in2;
    func      = v.func;
    cur       = v;
    cur_valid = 1'b1;
    cur_last  = last;
  endtask

  fpu UUT (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .in1_i       (in1),
    .in2_i       (in2),
    .func_i      (func),
    .out_o       (result),
    .overflow_o  (overflow),
    .underflow_o (underflow),
    .nan_o       (nan),
    .divzero_o   (divzero)
  );

  fpu_checker u_checker (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .out_i           (result),
    .overflow_i      (overflow),
    .underflow_i     (underflow),
    .nan_i           (nan),
    .divzero_i       (divzero),
    .exp_valid_i     (d2_valid),
    .exp_last_i      (d2_last),
    .exp_name_i      (d2.name),
    .exp_result_i    (d2.result),
    .exp_overflow_i  (d2.ovf),
    .exp_underflow_i (d2.unf),
    .exp_nan_i       (d2.nan),
    .fail_count_o    (fail_count),
    .done_o          (check_done)
  );

  // Expectations follow the operation through the two pipeline stages
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      d1_valid <= 1'b0;
      d1_last  <= 1'b0;
      d2_valid <= 1'b0;
      d2_last  <= 1'b0;
    end else begin
      d1       <= cur;
      d1_valid <= cur_valid;
      d1_last  <= cur_last;
      d2       <= d1;
      d2_valid <= d1_valid;
      d2_last  <= d1_last;
    end
  end

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst_n     = 1'b0;
    in1       = '0;
    in2       = '0;
    func      = '0;
    cur       = '0;
    cur_valid = 1'b0;
    cur_last  = 1'b0;
    fill_table();
    timeout_ns  = (table_q.size() + 10) * CLK_PERIOD;
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_SKEW;
    rst_n = 1'b1;
    foreach (table_q[i]) begin
      @(posedge clk);
      #DRIVE_SKEW;
      apply_vector(table_q[i], i == (table_q.size() - 1));
    end
    @(posedge clk);
    #DRIVE_SKEW;
    in1       = '0;
    in2       = '0;
    func      = '0;
    cur_valid = 1'b0;
    cur_last  = 1'b0;
    wait (check_done);
    if (fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    wait (table_ready);
    #(timeout_ns);
    $display("Run timed out after %0d ns before all results were checked", timeout_ns);
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== compile.f ====
source/float_pkg.sv
source/fpu_pkg.sv
source/fp_addsub.sv
source/fp_mult.sv
source/fp_convert.sv
source/fpu_control.sv
source/fpu.sv
tb/fpu_checker.sv
tb/fpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the FPU testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps -Wno-fatal --top-module fpu_tb \
  -f compile.f -o fpu_sim || exit 1
out=$(./obj_dir/fpu_sim)
echo "$out"
echo "$out" | grep -q "Testbench passed" && exit 0 || exit 1
